// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lsu_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/dmem.sv ====
module dmem
   import lsu_pkg::*;
#(
   parameter int MEM_P_WORDS = 8
)
(
   input  logic                   clk,
   input  logic                   stall,
   input  logic                   we,
   input  logic [MEM_P_WORDS-1:0] paddr,   // Word address
   input  logic [DW/8-1:0]        wmsk,
   input  lsu_word_u              wdat,
   output lsu_word_u              rdat
);
   lsu_word_u mem [1 << MEM_P_WORDS];

   // Byte lanes written under the mask
   always_ff @(posedge clk) begin
      if (we) begin
         for (int i = 0; i < DW/8; i++) begin
            if (wmsk[i]) begin
               mem[paddr].b[i] <= wdat.b[i];
            end
         end
      end
   end

   // Read port holds its word through a stall
   always_ff @(posedge clk) begin
      if (!stall) begin
         rdat <= mem[paddr];
      end
   end

endmodule

// ==== hw/dtlb.sv ====
module dtlb
   import lsu_pkg::*;
   import mmu_pkg::*;
#(
   parameter int TLB_P_SETS = 4
)
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  stall,
   input  logic                  tlb_req,
   input  logic [DW-1:0]         s1i_vaddr,
   input  logic                  s1i_store,
   input  logic                  s1o_valid,
   input  logic                  msr_psr_dmme,
   input  logic [TLB_P_SETS-1:0] msr_dmm_tlbl_idx,
   input  logic [DW-1:0]         msr_dmm_tlbl_nxt,
   input  logic                  msr_dmm_tlbl_we,
   input  logic [TLB_P_SETS-1:0] msr_dmm_tlbh_idx,
   input  logic [DW-1:0]         msr_dmm_tlbh_nxt,
   input  logic                  msr_dmm_tlbh_we,
   output logic [VPN_W-1:0]      ppn,
   output logic                  lsu_edtm,
   output logic                  lsu_edpf
);
   localparam int N = 1 << TLB_P_SETS;
   localparam int TAG_W = VPN_W - TLB_P_SETS;   // Index bits are not stored

   logic [N-1:0]            tlb_v;
   logic [TAG_W-1:0]        tlb_tag [N];
   logic [N-1:0]            tlb_r;
   logic [N-1:0]            tlb_w;
   logic [VPN_W-1:0]        tlb_ppn [N];
   logic [VPN_W-1:0]        vpn;
   logic [TLB_P_SETS-1:0]   idx;
   logic                    hit;
   logic                    perm_err;
   logic                    edtm_q;
   logic                    edpf_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tlb_v <= '0;
      end else if (msr_dmm_tlbl_we) begin
         tlb_v[msr_dmm_tlbl_idx] <= msr_dmm_tlbl_nxt[TLBL_V];
      end
   end

   always_ff @(posedge clk) begin
      if (msr_dmm_tlbl_we) begin
         tlb_tag[msr_dmm_tlbl_idx] <= msr_dmm_tlbl_nxt[TLBL_VPN_LSB+TLB_P_SETS +: TAG_W];
      end
      if (msr_dmm_tlbh_we) begin
         tlb_r[msr_dmm_tlbh_idx] <= msr_dmm_tlbh_nxt[TLBH_R];
         tlb_w[msr_dmm_tlbh_idx] <= msr_dmm_tlbh_nxt[TLBH_W];
         tlb_ppn[msr_dmm_tlbh_idx] <= msr_dmm_tlbh_nxt[TLBH_PPN_LSB +: VPN_W];
      end
   end

   assign vpn = s1i_vaddr[DW-1:P_PAGE_SIZE];
   assign idx = vpn[TLB_P_SETS-1:0];   // Direct mapped on the low VPN bits
   assign hit = tlb_v[idx] & (tlb_tag[idx] == vpn[VPN_W-1:TLB_P_SETS]);
   assign perm_err = s1i_store ? ~tlb_w[idx] : ~tlb_r[idx];

   // Flags only when translation is on
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         edtm_q <= 1'b0;
         edpf_q <= 1'b0;
      end else if (!stall) begin
         edtm_q <= tlb_req & msr_psr_dmme & ~hit;
         edpf_q <= tlb_req & msr_psr_dmme & hit & perm_err;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         ppn <= msr_psr_dmme ? tlb_ppn[idx] : vpn;   // Identity map when off
      end
   end

   assign lsu_edtm = s1o_valid & edtm_q;
   assign lsu_edpf = s1o_valid & edpf_q;

endmodule

// ==== hw/lsu_agu_stage.sv ====
module lsu_agu_stage
   import lsu_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic                stall,
   input  logic                flush_s1,
   input  logic                ex_valid,
   input  logic [LSU_IOPW-1:0] ex_lsu_opc,
   input  logic [DW-1:0]       add_sum,
   input  logic [DW-1:0]       ex_operand2,
   output logic                agu_en,
   output logic                tlb_req,
   output logic                s1o_valid,
   output logic                s1o_store,
   output logic [2:0]          s1o_size,
   output logic                s1o_sign_ext,
   output logic [DW-1:0]       s1o_vaddr,
   output logic [DW/8-1:0]     s1o_wmsk,
   output lsu_word_u           s1o_wdat,
   output logic                lsu_ealign
);
   logic            s1i_load;
   logic            s1i_store;
   logic            s1i_sign_ext;
   logic [2:0]      s1i_size;
   logic            s1i_valid;
   logic            s1i_misalign;
   logic [DW/8-1:0] s1i_wmsk;
   lsu_word_u       s1i_wdat;
   logic            s1o_misalign;

   assign s1i_load = ex_lsu_opc[LSU_LOAD];
   assign s1i_store = ex_lsu_opc[LSU_STORE];
   assign s1i_sign_ext = ex_lsu_opc[LSU_SIGN_EXT];
   assign s1i_size = ex_lsu_opc[LSU_SIZE_LSB +: 3];

   assign agu_en = s1i_load | s1i_store;
   assign s1i_valid = ex_valid & agu_en;

   // Lookup only for an access that really enters stage one
   assign tlb_req = ~stall & s1i_valid & ~flush_s1;

   assign s1i_misalign = ((s1i_size == SIZE_W) & (|add_sum[1:0])) |
                         ((s1i_size == SIZE_H) & add_sum[0]);

   // Store data is replicated to every lane, the mask picks the lane
   always_comb begin
      s1i_wdat.word = ex_operand2;
      s1i_wmsk = '1;
      case (s1i_size)
         SIZE_B: begin
            for (int i = 0; i < DW/8; i++) begin
               s1i_wdat.b[i] = ex_operand2[7:0];
            end
            s1i_wmsk = '0;
            s1i_wmsk[add_sum[1:0]] = 1'b1;
         end
         SIZE_H: begin
            for (int i = 0; i < DW/16; i++) begin
               s1i_wdat.h[i] = ex_operand2[15:0];
            end
            s1i_wmsk = add_sum[1] ? 4'b1100 : 4'b0011;
         end
         SIZE_W: s1i_wmsk = '1;
         default: s1i_wmsk = '1;
      endcase
      if (!s1i_store) begin
         s1i_wmsk = '0;   // Loads never write
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1o_valid <= 1'b0;
         s1o_misalign <= 1'b0;
      end else begin
         if (!stall || flush_s1) begin
            s1o_valid <= s1i_valid & ~flush_s1;
         end
         if (!stall) begin
            s1o_misalign <= s1i_misalign;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         s1o_store <= s1i_store;
         s1o_size <= s1i_size;
         s1o_sign_ext <= s1i_sign_ext;
         s1o_vaddr <= add_sum;
         s1o_wmsk <= s1i_wmsk;
         s1o_wdat <= s1i_wdat;
      end
   end

   assign lsu_ealign = s1o_valid & s1o_misalign;

endmodule

// ==== hw/lsu_load_align.sv ====
module lsu_load_align
   import lsu_pkg::*;
(
   input  logic          clk,
   input  logic          stall,
   input  logic [2:0]    s1o_size,
   input  logic          s1o_sign_ext,
   input  logic [1:0]    s1o_vaddr_lo,
   input  lsu_word_u     rdat,
   output logic [DW-1:0] lsu_dout
);
   logic [2:0]  s2o_size;
   logic        s2o_sign_ext;
   logic [1:0]  s2o_vaddr_lo;
   logic [7:0]  byte_sel;
   logic [15:0] half_sel;

   // Stage two follows the memory read by one edge
   always_ff @(posedge clk) begin
      if (!stall) begin
         s2o_size <= s1o_size;
         s2o_sign_ext <= s1o_sign_ext;
         s2o_vaddr_lo <= s1o_vaddr_lo;
      end
   end

   assign byte_sel = rdat.b[s2o_vaddr_lo];
   assign half_sel = rdat.h[s2o_vaddr_lo[1]];

   always_comb begin
      case (s2o_size)
         SIZE_B: lsu_dout = {{(DW-8){s2o_sign_ext & byte_sel[7]}}, byte_sel};
         SIZE_H: lsu_dout = {{(DW-16){s2o_sign_ext & half_sel[15]}}, half_sel};
         SIZE_W: lsu_dout = rdat.word;
         default: lsu_dout = rdat.word;   // Unused codes read the whole word
      endcase
   end

endmodule

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

   localparam int DW = 32;        // Data and address width
   localparam int LSU_IOPW = 6;   // Opcode bus width

   // Opcode bus bit positions
   localparam int LSU_LOAD = 0;
   localparam int LSU_STORE = 1;
   localparam int LSU_SIGN_EXT = 2;
   localparam int LSU_SIZE_LSB = 3;   // 3-bit size field

   // Access size codes, as carried in the size field
   localparam logic [2:0] SIZE_B = 3'd1;
   localparam logic [2:0] SIZE_H = 3'd2;
   localparam logic [2:0] SIZE_W = 3'd3;

   // One data word in three views
   // Byte and halfword lanes are little endian, lane 0 at the low address
   typedef union packed {
      logic [DW-1:0]          word;
      logic [DW/8-1:0][7:0]   b;
      logic [DW/16-1:0][15:0] h;
   } lsu_word_u;

endpackage

// ==== hw/lsu_top.sv ====
module lsu_top
   import lsu_pkg::*;
   import mmu_pkg::*;
#(
   parameter int TLB_P_SETS = 4,
   parameter int MEM_P_WORDS = 8
)
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  stall,
   input  logic                  flush_s1,
   input  logic                  ex_valid,
   input  logic [LSU_IOPW-1:0]   ex_lsu_opc,
   input  logic [DW-1:0]         add_sum,
   input  logic [DW-1:0]         ex_operand2,
   output logic                  agu_en,
   // To writeback
   output logic                  lsu_edtm,
   output logic                  lsu_edpf,
   output logic                  lsu_ealign,
   output logic [DW-1:0]         lsu_vaddr,
   output logic [DW-1:0]         lsu_dout,
   // Translation control
   input  logic                  msr_psr_dmme,
   input  logic [TLB_P_SETS-1:0] msr_dmm_tlbl_idx,
   input  logic [DW-1:0]         msr_dmm_tlbl_nxt,
   input  logic                  msr_dmm_tlbl_we,
   input  logic [TLB_P_SETS-1:0] msr_dmm_tlbh_idx,
   input  logic [DW-1:0]         msr_dmm_tlbh_nxt,
   input  logic                  msr_dmm_tlbh_we
);
   logic             tlb_req;
   logic             s1o_valid;
   logic             s1o_store;
   logic [2:0]       s1o_size;
   logic             s1o_sign_ext;
   logic [DW-1:0]    s1o_vaddr;
   logic [DW/8-1:0]  s1o_wmsk;
   lsu_word_u        s1o_wdat;
   logic [VPN_W-1:0] s2i_ppn;
   logic [DW-1:0]    s2i_paddr;
   logic             mem_we;
   lsu_word_u        mem_rdat;

   lsu_agu_stage u_agu (
      .clk          (clk),
      .arst_n       (arst_n),
      .stall        (stall),
      .flush_s1     (flush_s1),
      .ex_valid     (ex_valid),
      .ex_lsu_opc   (ex_lsu_opc),
      .add_sum      (add_sum),
      .ex_operand2  (ex_operand2),
      .agu_en       (agu_en),
      .tlb_req      (tlb_req),
      .s1o_valid    (s1o_valid),
      .s1o_store    (s1o_store),
      .s1o_size     (s1o_size),
      .s1o_sign_ext (s1o_sign_ext),
      .s1o_vaddr    (s1o_vaddr),
      .s1o_wmsk     (s1o_wmsk),
      .s1o_wdat     (s1o_wdat),
      .lsu_ealign   (lsu_ealign)
   );

   dtlb #(.TLB_P_SETS(TLB_P_SETS)) u_dtlb (
      .clk              (clk),
      .arst_n           (arst_n),
      .stall            (stall),
      .tlb_req          (tlb_req),
      .s1i_vaddr        (add_sum),
      .s1i_store        (ex_lsu_opc[LSU_STORE]),
      .s1o_valid        (s1o_valid),
      .msr_psr_dmme     (msr_psr_dmme),
      .msr_dmm_tlbl_idx (msr_dmm_tlbl_idx),
      .msr_dmm_tlbl_nxt (msr_dmm_tlbl_nxt),
      .msr_dmm_tlbl_we  (msr_dmm_tlbl_we),
      .msr_dmm_tlbh_idx (msr_dmm_tlbh_idx),
      .msr_dmm_tlbh_nxt (msr_dmm_tlbh_nxt),
      .msr_dmm_tlbh_we  (msr_dmm_tlbh_we),
      .ppn              (s2i_ppn),
      .lsu_edtm         (lsu_edtm),
      .lsu_edpf         (lsu_edpf)
   );

   assign s2i_paddr = {s2i_ppn, s1o_vaddr[P_PAGE_SIZE-1:0]};

   // Any stage-one exception kills the store
   assign mem_we = s1o_valid & s1o_store & ~stall & ~(lsu_ealign | lsu_edtm | lsu_edpf);

   dmem #(.MEM_P_WORDS(MEM_P_WORDS)) u_dmem (
      .clk   (clk),
      .stall (stall),
      .we    (mem_we),
      .paddr (s2i_paddr[MEM_P_WORDS+1:2]),   // Word index
      .wmsk  (s1o_wmsk),
      .wdat  (s1o_wdat),
      .rdat  (mem_rdat)
   );

   lsu_load_align u_align (
      .clk          (clk),
      .stall        (stall),
      .s1o_size     (s1o_size),
      .s1o_sign_ext (s1o_sign_ext),
      .s1o_vaddr_lo (s1o_vaddr[1:0]),
      .rdat         (mem_rdat),
      .lsu_dout     (lsu_dout)
   );

   assign lsu_vaddr = s1o_vaddr;

endmodule

// ==== hw/mmu_pkg.sv ====
package mmu_pkg;

   // Page geometry
   localparam int P_PAGE_SIZE = 12;   // Page offset bits
   localparam int VPN_W = 20;         // Page number width

   // Low word of a TLB entry
   //   [0]     valid
   //   [31:12] virtual page tag
   localparam int TLBL_V = 0;
   localparam int TLBL_VPN_LSB = 12;

   // High word of a TLB entry
   //   [0]     readable
   //   [1]     writable
   //   [31:12] physical page number
   localparam int TLBH_R = 0;
   localparam int TLBH_W = 1;
   localparam int TLBH_PPN_LSB = 12;

endpackage

// ==== sim.f ====
hw/lsu_pkg.sv
hw/mmu_pkg.sv
hw/lsu_agu_stage.sv
hw/dtlb.sv
hw/dmem.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

// ==== verif/lsu_checker.sv ====
module lsu_checker
   import lsu_pkg::*;
(
   input logic                clk,
   input logic                arst_n,
   input logic                flush_s1,
   input logic [LSU_IOPW-1:0] ex_lsu_opc,
   input logic                agu_en,
   input logic                lsu_edtm,
   input logic                lsu_edpf,
   input logic                lsu_ealign,
   input logic [2:0]          s1o_size
);
   int assert_errs = 0;   // Read by the testbench at the end

   // Stage one is empty the cycle after reset or a flush
   a_reset_clean: assert property (@(posedge clk)
      !arst_n |=> !(lsu_edtm | lsu_edpf | lsu_ealign))
      else begin
         $error("exception output high after reset");
         assert_errs++;
      end

   a_flush_clean: assert property (@(posedge clk) disable iff (!arst_n)
      flush_s1 |=> !(lsu_edtm | lsu_edpf | lsu_ealign))
      else begin
         $error("exception output high after flush");
         assert_errs++;
      end

   a_byte_aligned: assert property (@(posedge clk) disable iff (!arst_n)
      lsu_ealign |-> (s1o_size != SIZE_B))
      else begin
         $error("misalign raised for a byte access");
         assert_errs++;
      end

   a_agu_en: assert property (@(posedge clk) disable iff (!arst_n)
      agu_en == (ex_lsu_opc[LSU_LOAD] | ex_lsu_opc[LSU_STORE]))
      else begin
         $error("agu_en does not follow the opcode");
         assert_errs++;
      end

endmodule

bind lsu_top lsu_checker chk_i (
   .clk        (clk),
   .arst_n     (arst_n),
   .flush_s1   (flush_s1),
   .ex_lsu_opc (ex_lsu_opc),
   .agu_en     (agu_en),
   .lsu_edtm   (lsu_edtm),
   .lsu_edpf   (lsu_edpf),
   .lsu_ealign (lsu_ealign),
   .s1o_size   (s1o_size)
);

// ==== verif/lsu_tb.sv ====
module lsu_tb
   import lsu_pkg::*;
;
   localparam int NROWS = 43;
   localparam int FILL_WORDS = 32;   // Bytes 0x00 to 0x7f
   localparam int MAX_CYCLES = FILL_WORDS + 20 + NROWS * 5 + 20;

   // Opcodes are {size, sign, store, load}
   localparam logic [LSU_IOPW-1:0] OP_LW = {SIZE_W, 3'b001};
   localparam logic [LSU_IOPW-1:0] OP_LH = {SIZE_H, 3'b101};
   localparam logic [LSU_IOPW-1:0] OP_LHU = {SIZE_H, 3'b001};
   localparam logic [LSU_IOPW-1:0] OP_LB = {SIZE_B, 3'b101};
   localparam logic [LSU_IOPW-1:0] OP_LBU = {SIZE_B, 3'b001};
   localparam logic [LSU_IOPW-1:0] OP_SW = {SIZE_W, 3'b010};
   localparam logic [LSU_IOPW-1:0] OP_SH = {SIZE_H, 3'b010};
   localparam logic [LSU_IOPW-1:0] OP_SB = {SIZE_B, 3'b010};

   typedef struct {
      logic [LSU_IOPW-1:0] opc;
      logic [DW-1:0]       addr;
      logic [DW-1:0]       wdat;
      logic                dmme;
      logic                flush;
      logic                stall;
      logic                edtm;
      logic                edpf;
      logic                ealign;
   } row_t;

   logic                clk = 1'b0;
   logic                arst_n;
   logic                stall;
   logic                flush_s1;
   logic                ex_valid;
   logic [LSU_IOPW-1:0] ex_lsu_opc;
   logic [DW-1:0]       add_sum;
   logic [DW-1:0]       ex_operand2;
   logic                msr_psr_dmme;
   logic [3:0]          tlbl_idx;
   logic [DW-1:0]       tlbl_nxt;
   logic                tlbl_we;
   logic [3:0]          tlbh_idx;
   logic [DW-1:0]       tlbh_nxt;
   logic                tlbh_we;
   logic                agu_en;
   logic                lsu_edtm;
   logic                lsu_edpf;
   logic                lsu_ealign;
   logic [DW-1:0]       lsu_vaddr;
   logic [DW-1:0]       lsu_dout;

   row_t        tbl [NROWS];
   int          nrow = 0;
   int          errors = 0;
   int          seed = 32'h19f0;
   logic [7:0]  ref_mem [1024];   // Physical bytes, aliased like the 1 KB memory
   logic [19:0] tlb_ref_ppn [16];

   lsu_top #(.TLB_P_SETS(4), .MEM_P_WORDS(8)) dut_i (
      .clk(clk), .arst_n(arst_n), .stall(stall), .flush_s1(flush_s1),
      .ex_valid(ex_valid), .ex_lsu_opc(ex_lsu_opc), .add_sum(add_sum),
      .ex_operand2(ex_operand2), .agu_en(agu_en), .lsu_edtm(lsu_edtm),
      .lsu_edpf(lsu_edpf), .lsu_ealign(lsu_ealign), .lsu_vaddr(lsu_vaddr),
      .lsu_dout(lsu_dout), .msr_psr_dmme(msr_psr_dmme),
      .msr_dmm_tlbl_idx(tlbl_idx), .msr_dmm_tlbl_nxt(tlbl_nxt), .msr_dmm_tlbl_we(tlbl_we),
      .msr_dmm_tlbh_idx(tlbh_idx), .msr_dmm_tlbh_nxt(tlbh_nxt), .msr_dmm_tlbh_we(tlbh_we)
   );

   always #50 clk = ~clk;

   task automatic check_word(input string name, input lsu_word_u got, input lsu_word_u exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got.word, exp.word);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Flags are {dmme, flush, stall, edtm, edpf, ealign}
   task automatic add_row(input logic [LSU_IOPW-1:0] opc, input logic [DW-1:0] addr,
                          input logic [DW-1:0] wdat, input logic [5:0] fl);
      tbl[nrow] = '{opc, addr, wdat, fl[5], fl[4], fl[3], fl[2], fl[1], fl[0]};
      nrow++;
   endtask

   function automatic logic [DW-1:0] phys_addr(input logic [DW-1:0] vaddr, input logic dmme);
      if (dmme) begin
         return {tlb_ref_ppn[vaddr[15:12]], vaddr[11:0]};
      end
      return vaddr;   // Identity map
   endfunction

   function automatic logic [DW-1:0] expected_load(input logic [LSU_IOPW-1:0] opc,
                                                   input logic [DW-1:0] pa);
      logic [9:0]  a;
      logic [7:0]  b;
      logic [15:0] h;
      logic        sx;
      a = pa[9:0];
      sx = opc[LSU_SIGN_EXT];
      case (opc[LSU_SIZE_LSB +: 3])
         SIZE_B: begin
            b = ref_mem[a];
            return {{24{sx & b[7]}}, b};
         end
         SIZE_H: begin
            h = {ref_mem[{a[9:1], 1'b1}], ref_mem[{a[9:1], 1'b0}]};
            return {{16{sx & h[15]}}, h};
         end
         default: return {ref_mem[{a[9:2], 2'd3}], ref_mem[{a[9:2], 2'd2}],
                          ref_mem[{a[9:2], 2'd1}], ref_mem[{a[9:2], 2'd0}]};
      endcase
   endfunction

   task automatic update_ref(input logic [LSU_IOPW-1:0] opc, input logic [DW-1:0] pa,
                             input logic [DW-1:0] d);
      logic [9:0] a;
      a = pa[9:0];
      case (opc[LSU_SIZE_LSB +: 3])
         SIZE_B: ref_mem[a] = d[7:0];
         SIZE_H: begin
            ref_mem[{a[9:1], 1'b0}] = d[7:0];
            ref_mem[{a[9:1], 1'b1}] = d[15:8];
         end
         default: begin
            ref_mem[{a[9:2], 2'd0}] = d[7:0];
            ref_mem[{a[9:2], 2'd1}] = d[15:8];
            ref_mem[{a[9:2], 2'd2}] = d[23:16];
            ref_mem[{a[9:2], 2'd3}] = d[31:24];
         end
      endcase
   endtask

   task automatic write_tlb(input logic [3:0] idx, input logic [DW-1:0] lo,
                            input logic [DW-1:0] hi);
      @(posedge clk);
      #10;
      tlbl_idx = idx;
      tlbl_nxt = lo;
      tlbl_we = 1'b1;
      tlbh_idx = idx;
      tlbh_nxt = hi;
      tlbh_we = 1'b1;
      tlb_ref_ppn[idx] = hi[31:12];
      @(posedge clk);
      #10;
      tlbl_we = 1'b0;
      tlbh_we = 1'b0;
   endtask

   task automatic run_row(input row_t r);
      logic [DW-1:0] pa;
      lsu_word_u     hold_dout;
      logic          exc;
      exc = r.edtm | r.edpf | r.ealign;
      pa = phys_addr(r.addr, r.dmme);
      @(posedge clk);
      #10;
      ex_valid = 1'b1;
      ex_lsu_opc = r.opc;
      add_sum = r.addr;
      ex_operand2 = r.wdat;
      msr_psr_dmme = r.dmme;
      flush_s1 = r.flush;
      @(negedge clk);
      check_flag("agu_en", agu_en, 1'b1);
      @(posedge clk);   // Access enters stage one
      #10;
      ex_valid = 1'b0;
      ex_lsu_opc = '0;
      add_sum = ~r.addr;   // A held stage one must not take this address
      flush_s1 = 1'b0;
      stall = r.stall;
      @(negedge clk);
      check_flag("agu_en", agu_en, 1'b0);
      check_flag("lsu_edtm", lsu_edtm, r.edtm);
      check_flag("lsu_edpf", lsu_edpf, r.edpf);
      check_flag("lsu_ealign", lsu_ealign, r.ealign);
      check_addr("lsu_vaddr", lsu_vaddr, r.addr);
      if (r.stall) begin
         hold_dout = lsu_dout;
         @(posedge clk);
         @(negedge clk);
         check_addr("lsu_vaddr", lsu_vaddr, r.addr);
         check_word("lsu_dout", lsu_dout, hold_dout);
         @(posedge clk);
         #10;
         stall = 1'b0;
      end
      @(posedge clk);   // Memory write or read
      @(negedge clk);
      if (!r.flush && !exc) begin
         if (r.opc[LSU_STORE]) begin
            update_ref(r.opc, pa, r.wdat);
         end else begin
            check_word("lsu_dout", lsu_dout, expected_load(r.opc, pa));
         end
      end
   endtask

   task automatic build_table();
      // Aligned stores and loads at every offset
      add_row(OP_SW, 32'h10, 32'h8081_82f3, 6'b000000);
      add_row(OP_LW, 32'h10, 32'h0, 6'b000000);
      add_row(OP_LB, 32'h10, 32'h0, 6'b000000);
      add_row(OP_LB, 32'h11, 32'h0, 6'b000000);
      add_row(OP_LB, 32'h12, 32'h0, 6'b000000);
      add_row(OP_LB, 32'h13, 32'h0, 6'b000000);
      add_row(OP_LBU, 32'h13, 32'h0, 6'b000000);
      add_row(OP_LH, 32'h10, 32'h0, 6'b000000);
      add_row(OP_LH, 32'h12, 32'h0, 6'b000000);
      add_row(OP_LHU, 32'h12, 32'h0, 6'b000000);
      add_row(OP_SB, 32'h21, 32'h0000_00a5, 6'b000000);
      add_row(OP_LBU, 32'h21, 32'h0, 6'b000000);
      add_row(OP_LB, 32'h21, 32'h0, 6'b000000);
      add_row(OP_LW, 32'h20, 32'h0, 6'b000000);
      add_row(OP_SH, 32'h26, 32'h0000_8001, 6'b000000);
      add_row(OP_LH, 32'h26, 32'h0, 6'b000000);
      add_row(OP_LHU, 32'h26, 32'h0, 6'b000000);
      add_row(OP_LW, 32'h24, 32'h0, 6'b000000);
      // Misaligned accesses
      add_row(OP_LW, 32'h31, 32'h0, 6'b000001);
      add_row(OP_SW, 32'h32, 32'hffff_ffff, 6'b000001);
      add_row(OP_LW, 32'h30, 32'h0, 6'b000000);
      add_row(OP_LH, 32'h33, 32'h0, 6'b000001);
      add_row(OP_SH, 32'h35, 32'h0000_ffff, 6'b000001);
      add_row(OP_LW, 32'h34, 32'h0, 6'b000000);
      add_row(OP_LB, 32'h33, 32'h0, 6'b000000);
      // Translation on
      add_row(OP_LW, 32'h0004_4000, 32'h0, 6'b100100);   // Invalid entry
      add_row(OP_LW, 32'h0005_1010, 32'h0, 6'b100100);   // Tag mismatch
      add_row(OP_SW, 32'h0002_2040, 32'h0bad_0bad, 6'b100010);
      add_row(OP_LW, 32'h0003_3040, 32'h0, 6'b100010);
      add_row(OP_SW, 32'h0003_3040, 32'h1234_5678, 6'b100000);
      add_row(OP_LW, 32'h0001_1040, 32'h0, 6'b100000);
      add_row(OP_SB, 32'h0001_1045, 32'h0000_0077, 6'b100000);
      add_row(OP_LW, 32'h0002_2044, 32'h0, 6'b100000);
      // Translation off
      add_row(OP_LW, 32'h0004_4040, 32'h0, 6'b000000);
      add_row(OP_SW, 32'hffff_f048, 32'hcafe_f00d, 6'b000000);
      add_row(OP_LW, 32'h48, 32'h0, 6'b000000);
      // Flushed accesses
      add_row(OP_SW, 32'h50, 32'hdead_beef, 6'b010000);
      add_row(OP_LW, 32'h50, 32'h0, 6'b000000);
      add_row(OP_LW, 32'h51, 32'h0, 6'b010000);
      add_row(OP_LW, 32'h0004_4000, 32'h0, 6'b110000);
      // Stalled accesses
      add_row(OP_SW, 32'h58, 32'h1357_9bdf, 6'b001000);
      add_row(OP_LW, 32'h58, 32'h0, 6'b001000);
      add_row(OP_LH, 32'h5a, 32'h0, 6'b001000);
   endtask

   initial begin
      #(MAX_CYCLES * 100);
      $display("Timeout: the test did not finish in the expected time");
      $display("Something failed");
      $finish;
   end

   initial begin
      logic [DW-1:0] w;
      arst_n = 1'b0;
      stall = 1'b0;
      flush_s1 = 1'b0;
      ex_valid = 1'b0;
      ex_lsu_opc = '0;
      add_sum = '0;
      ex_operand2 = '0;
      msr_psr_dmme = 1'b0;
      tlbl_idx = '0;
      tlbl_nxt = '0;
      tlbl_we = 1'b0;
      tlbh_idx = '0;
      tlbh_nxt = '0;
      tlbh_we = 1'b0;
      build_table();
      repeat (2) @(posedge clk);
      #10;
      arst_n = 1'b1;

      // Entries {vpn, v} and {ppn, w, r}
      write_tlb(4'd1, 32'h0001_1001, 32'h0000_7003);   // Read and write
      write_tlb(4'd2, 32'h0002_2001, 32'h0000_8001);   // Read only
      write_tlb(4'd3, 32'h0003_3001, 32'h0000_9002);   // Write only

      // Random fill, back to back word stores
      for (int i = 0; i < FILL_WORDS; i++) begin
         @(posedge clk);
         #10;
         w = $random(seed);
         ex_valid = 1'b1;
         ex_lsu_opc = OP_SW;
         add_sum = 32'(i * 4);
         ex_operand2 = w;
         update_ref(OP_SW, add_sum, w);
      end
      @(posedge clk);
      #10;
      ex_valid = 1'b0;
      ex_lsu_opc = '0;

      for (int i = 0; i < NROWS; i++) begin
         run_row(tbl[i]);
      end

      $display("Checks done, errors: %0d, assertion errors: %0d",
               errors, dut_i.chk_i.assert_errs);
      if (errors == 0 && dut_i.chk_i.assert_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
